// File: saturn_bus.f
+incdir+logic
logic/saturn_bus_pkg.sv
logic/saturn_phase_gen.sv
logic/saturn_bus_controller.sv
logic/saturn_hp48gx_rom.sv
logic/saturn_sys_ram.sv
logic/saturn_debug_port.sv
logic/saturn_bus.sv
tests/saturn_bus_assert.sv
tests/saturn_bus_checker.sv
tests/saturn_bus_tb.sv

// File: tests/saturn_bus_tb.sv
// Testbench for the nibble bus system. Seeded random requests against a memory model.
`timescale 1ns/1ps
`include "saturn_bus_settings.svh"

module saturn_bus_tb;

    import saturn_bus_pkg::*;

    localparam int N_REQ          = 300;
    localparam int N_RW           = 296;        // Then one halt and three ignored.
    localparam int EXP_TESTS      = N_REQ + 1;  // Plus the reset test.
    localparam int TIMEOUT_CYCLES = N_REQ * 9 * 4 * 8;

    logic                      i_clk;
    logic                      i_reset;
    logic                      i_clk_en;
    logic                      i_start;
    host_op_e                  i_op;
    logic [`SATURN_ADDR_W-1:0] i_addr;
    logic [3:0]                i_wdata;
    logic                      i_char_ready;
    logic                      o_busy;
    logic                      o_done;
    logic [3:0]                o_rdata;
    logic                      o_halt;
    logic [1:0]                o_phase;
    logic [31:0]               o_cycle_ctr;
    logic [7:0]                o_char_to_send;
    logic                      o_char_valid;

    integer                    seed;
    int                        clk_cnt;
    int                        test_cnt;
    int                        err_cnt;
    int                        assert_errs;
    logic [15:0]               req_id;
    logic [3:0]                exp_rdata;
    logic [7:0]                exp_char;
    logic [3:0]                ram_model [`SATURN_RAM_DEPTH];   // Mirror of the RAM.
    logic [3:0]                dbg_lo;
    host_op_e                  req_op    [N_REQ];
    logic [`SATURN_ADDR_W-1:0] req_addr  [N_REQ];
    logic [3:0]                req_wdata [N_REQ];
    logic [31:0]               base_ctr;

    saturn_bus dut_i (.*);

    saturn_bus_checker checker_i (
        .i_clk (i_clk), .i_reset (i_reset), .i_start (i_start), .i_op (i_op),
        .i_addr (i_addr), .i_req_id (req_id), .i_exp_rdata (exp_rdata),
        .i_exp_char (exp_char), .i_busy (o_busy), .i_done (o_done),
        .i_rdata (o_rdata), .i_halt (o_halt), .i_phase (o_phase),
        .i_cycle_ctr (o_cycle_ctr), .i_char (o_char_to_send),
        .i_char_valid (o_char_valid), .i_char_ready (i_char_ready),
        .o_test_cnt (test_cnt), .o_err_cnt (err_cnt)
    );

    always #20 i_clk = ~i_clk;    // 40 ns period.

    // Enable 3 clocks in 4, serial sink ready half the time.
    always @(posedge i_clk) begin
        #2;
        i_clk_en     = (($random(seed) & 3) != 0);
        i_char_ready = $random(seed) & 1;
    end

    always @(posedge i_clk) begin
        clk_cnt++;
        if (clk_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d clocks", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ROM contents. Nibble sum of the address.
    function automatic logic [3:0] rom_rule(input logic [`SATURN_ADDR_W-1:0] a);
        logic [3:0] sum;
        sum = 4'h0;
        for (int i = 0; i < 5; i++) sum = sum + a[4*i +: 4];
        return sum;
    endfunction

    function automatic logic [3:0] expected_read(input logic [`SATURN_ADDR_W-1:0] a);
        if (a <= `SATURN_ROM_TOP) return rom_rule(a);
        if (a >= `SATURN_RAM_BASE && a < `SATURN_RAM_BASE + `SATURN_RAM_DEPTH)
            return ram_model[int'(a - `SATURN_RAM_BASE)];
        return 4'h0;    // Debug pair and holes read zero.
    endfunction

    // Request table, drawn before the clock runs.
    task automatic build_requests();
        int region;
        req_op[0]    = OP_WRITE;                // Seed the low half of a character.
        req_addr[0]  = `SATURN_DBG_LO;
        req_wdata[0] = $random(seed) & 15;
        for (int k = 1; k < N_REQ; k++) begin
            region       = $random(seed) & 3;
            req_op[k]    = ($random(seed) & 1) ? OP_WRITE : OP_READ;
            req_wdata[k] = $random(seed) & 15;
            case (region)
                0:       req_addr[k] = $random(seed) & `SATURN_ROM_TOP;
                1:       req_addr[k] = `SATURN_RAM_BASE + ($random(seed) & 63);
                2:       req_addr[k] = `SATURN_DBG_LO + ($random(seed) & 1);
                default: req_addr[k] = 20'h80040 + ($random(seed) & 20'h3FFFF);
            endcase
        end
        req_op[N_RW] = OP_HALT;
    endtask

    task automatic issue_start(input int idx);
        @(posedge i_clk);
        #2;
        i_start   = 1'b1;
        i_op      = req_op[idx];
        i_addr    = req_addr[idx];
        i_wdata   = req_wdata[idx];
        req_id    = idx;
        exp_rdata = expected_read(req_addr[idx]);
        if (req_op[idx] == OP_WRITE && req_addr[idx] == `SATURN_DBG_HI)
            exp_char = {req_wdata[idx], dbg_lo};
        @(posedge i_clk);
        #2;
        i_start = 1'b0;
    endtask

    task automatic run_request(input int idx);
        logic [`SATURN_ADDR_W-1:0] a;
        a = req_addr[idx];
        issue_start(idx);
        do @(negedge i_clk); while (o_done !== 1'b1);
        if (req_op[idx] == OP_WRITE) begin       // Model follows the write.
            if (a >= `SATURN_RAM_BASE && a < `SATURN_RAM_BASE + `SATURN_RAM_DEPTH)
                ram_model[int'(a - `SATURN_RAM_BASE)] = req_wdata[idx];
            if (a == `SATURN_DBG_LO) dbg_lo = req_wdata[idx];
        end
    endtask

    initial begin
        seed         = 68;
        clk_cnt      = 0;
        i_clk        = 1'b0;
        i_reset      = 1'b1;
        i_clk_en     = 1'b0;
        i_start      = 1'b0;
        i_op         = OP_READ;
        i_addr       = '0;
        i_wdata      = 4'h0;
        i_char_ready = 1'b0;
        req_id       = '0;
        exp_rdata    = 4'h0;
        exp_char     = 8'h00;
        dbg_lo       = 4'h0;
        for (int i = 0; i < `SATURN_RAM_DEPTH; i++) ram_model[i] = 4'h0;
        build_requests();
        repeat (2) @(posedge i_clk);
        #2;
        i_reset = 1'b0;
        for (int k = 0; k < N_RW; k++) run_request(k);
        issue_start(N_RW);                       // Halt.
        do @(negedge i_clk); while (o_halt !== 1'b1);
        for (int k = N_RW + 1; k < N_REQ; k++) begin
            issue_start(k);
            base_ctr = o_cycle_ctr;
            do @(negedge i_clk); while (o_cycle_ctr < base_ctr + 32'd12);
        end
        repeat (2) @(posedge i_clk);
        assert_errs = dut_i.controller_i.assert_i.assert_fails;
        $display("summary: %0d tests of %0d, %0d check errors, %0d assertion errors",
                 test_cnt, EXP_TESTS, err_cnt, assert_errs);
        if (test_cnt != EXP_TESTS) $display("error: not every request was scored");
        if (err_cnt == 0 && assert_errs == 0 && test_cnt == EXP_TESTS) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: tests/saturn_bus_checker.sv
// Scoreboard for the nibble bus. Watches the top-level ports and scores each request.
`timescale 1ns/1ps
`include "saturn_bus_settings.svh"

module saturn_bus_checker (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_start,
    input  saturn_bus_pkg::host_op_e  i_op,
    input  logic [`SATURN_ADDR_W-1:0] i_addr,
    input  logic [15:0]               i_req_id,
    input  logic [3:0]                i_exp_rdata,
    input  logic [7:0]                i_exp_char,
    input  logic                      i_busy,
    input  logic                      i_done,
    input  logic [3:0]                i_rdata,
    input  logic                      i_halt,
    input  logic [1:0]                i_phase,
    input  logic [31:0]               i_cycle_ctr,
    input  logic [7:0]                i_char,
    input  logic                      i_char_valid,
    input  logic                      i_char_ready,
    output int                        o_test_cnt,
    output int                        o_err_cnt
);

    import saturn_bus_pkg::*;

    host_op_e                  cur_op;
    logic [`SATURN_ADDR_W-1:0] cur_addr;
    logic [3:0]                cur_exp;
    string                     cur_name;
    logic        pending;      // Read or write in flight.
    logic        rec_ctr;      // Grab the start count next clock.
    logic        halt_wait;
    logic        ign_wait;     // Start issued after halt.
    logic        test_bad;
    logic        char_seen;
    logic        rst_q;
    logic        hold_q;       // Character held, not taken.
    logic        halt_q;
    logic [31:0] start_ctr;
    logic [31:0] ign_ctr;
    logic [31:0] ctr_q;
    logic [7:0]  char_q;
    logic [1:0]  phase_q;

    initial begin
        o_test_cnt = 0;
        o_err_cnt  = 0;
    end

    function automatic string op_label(input host_op_e op);
        case (op)
            OP_READ:  return "read";
            OP_WRITE: return "write";
            OP_HALT:  return "halt";
            default:  return "badop";
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("mismatch %s %s expected %0h actual %0h", cur_name, what, exp, act);
        o_err_cnt++;
        test_bad = 1'b1;
    endtask

    task automatic report_error(input string msg);
        $display("error in %s: %s", cur_name, msg);
        o_err_cnt++;
        test_bad = 1'b1;
    endtask

    task automatic close_test();
        o_test_cnt++;
        $display("test %s %s", cur_name, test_bad ? "failed" : "passed");
    endtask

    // ######################################################################
    // Sampling at each rising edge, values from the clock just ended
    // ######################################################################
    always @(posedge i_clk) begin
        if (i_reset) begin
            pending   = 1'b0;
            rec_ctr   = 1'b0;
            halt_wait = 1'b0;
            ign_wait  = 1'b0;
            hold_q    = 1'b0;
            halt_q    = 1'b0;
            rst_q     = 1'b1;
        end else begin
            if (rst_q) begin                       // First clock out of reset.
                cur_name = "reset";
                test_bad = 1'b0;
                if (i_phase != 2'd0) report_mismatch("phase", 0, i_phase);
                if (i_cycle_ctr != 0) report_mismatch("cycle_ctr", 0, i_cycle_ctr);
                if (i_busy) report_error("o_busy high after reset");
                if (i_halt) report_error("o_halt high after reset");
                close_test();
            end
            if (hold_q) begin                      // Stalled clock must freeze all.
                if (!i_char_valid) report_error("character dropped before it was taken");
                if (i_char != char_q) report_mismatch("held_char", char_q, i_char);
                if (i_cycle_ctr != ctr_q) report_mismatch("stall_cycle_ctr", ctr_q, i_cycle_ctr);
                if (i_phase != phase_q) report_mismatch("stall_phase", phase_q, i_phase);
            end
            if (i_char_valid && i_char_ready) begin   // Character taken.
                char_seen = 1'b1;
                if (i_char != i_exp_char) report_mismatch("char", i_exp_char, i_char);
            end
            if (halt_q && !i_halt) report_error("o_halt fell without reset");
            if (halt_wait) begin
                halt_wait = 1'b0;
                if (!i_halt) report_error("o_halt not raised one clock after halt");
                close_test();
            end
            if (rec_ctr) begin
                start_ctr = i_cycle_ctr;
                rec_ctr   = 1'b0;
            end
            if (i_done) begin
                if (!pending) begin
                    report_error("o_done with no request pending");
                end else begin
                    pending = 1'b0;
                    if (i_cycle_ctr != start_ctr + 32'd9)
                        report_mismatch("bus_cycles", start_ctr + 32'd9, i_cycle_ctr);
                    if (cur_op == OP_READ && i_rdata != cur_exp)
                        report_mismatch("rdata", cur_exp, i_rdata);
                    if (cur_op == OP_WRITE && cur_addr == `SATURN_DBG_HI && !char_seen)
                        report_error("debug character never taken");
                    close_test();
                end
            end
            if (ign_wait && i_cycle_ctr >= ign_ctr + 32'd12) begin   // Quiet window over.
                ign_wait = 1'b0;
                close_test();
            end
            if (i_start && !i_busy && !i_halt) begin
                cur_op    = i_op;
                cur_addr  = i_addr;
                cur_exp   = i_exp_rdata;
                cur_name  = $sformatf("req%0d_%s_%05h", i_req_id, op_label(i_op), i_addr);
                test_bad  = 1'b0;
                char_seen = 1'b0;
                if (i_op == OP_HALT) begin
                    halt_wait = 1'b1;
                end else begin
                    pending = 1'b1;
                    rec_ctr = 1'b1;
                end
            end else if (i_start && i_halt) begin   // Must be ignored.
                cur_name = $sformatf("req%0d_after_halt", i_req_id);
                test_bad = 1'b0;
                ign_wait = 1'b1;
                ign_ctr  = i_cycle_ctr;
            end
            rst_q   = 1'b0;
            halt_q  = i_halt;
            hold_q  = i_char_valid && !i_char_ready;
            ctr_q   = i_cycle_ctr;
            char_q  = i_char;
            phase_q = i_phase;
        end
    end

endmodule

// File: tests/saturn_bus_assert.sv
// Protocol assertions for the bus controller, bound into every controller instance.
`timescale 1ns/1ps

module saturn_bus_assert (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_strobe,
    input  logic i_done,
    input  logic i_rom_drive,
    input  logic i_ram_drive,
    input  logic i_stall,
    input  logic i_char_valid
);

    int assert_fails = 0;    // Read by the testbench at the end.

    // Done is a single-clock pulse.
    a_done_pulse : assert property (@(posedge i_clk) disable iff (i_reset)
        i_done |=> !i_done)
        else begin
            assert_fails++;
            $error("o_done high on two consecutive clocks");
        end

    // ROM and RAM windows never overlap on the bus.
    a_drive_excl : assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_rom_drive && i_ram_drive))
        else begin
            assert_fails++;
            $error("ROM and RAM drive the bus together");
        end

    // Back-pressure starts only after a strobe or with a character already waiting.
    a_stall_src : assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_stall) |-> ($past(i_strobe) || $past(i_char_valid)))
        else begin
            assert_fails++;
            $error("stall raised with no bus write and no character pending");
        end

endmodule

bind saturn_bus_controller saturn_bus_assert assert_i (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_strobe     (i_strobe),
    .i_done       (o_done),
    .i_rom_drive  (i_rom_drive),
    .i_ram_drive  (i_ram_drive),
    .i_stall      (o_stall),
    .i_char_valid (i_char_valid)
);

// File: logic/saturn_bus.sv
// Top of the nibble bus system. Phase generator, bus master and three devices.
`timescale 1ns/1ps
`include "saturn_bus_settings.svh"

module saturn_bus (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_clk_en,
    input  logic                      i_start,
    input  saturn_bus_pkg::host_op_e  i_op,
    input  logic [`SATURN_ADDR_W-1:0] i_addr,
    input  logic [3:0]                i_wdata,
    output logic                      o_busy,
    output logic                      o_done,
    output logic [3:0]                o_rdata,
    output logic                      o_halt,
    output logic [1:0]                o_phase,
    output logic [31:0]               o_cycle_ctr,
    output logic [7:0]                o_char_to_send,
    output logic                      o_char_valid,
    input  logic                      i_char_ready
);

    // ##########################################################################
    // Bus wiring
    // ##########################################################################
    logic       bus_strobe;     // One per bus cycle.
    logic       phase_stall;    // Serial back-pressure.
    logic [3:0] ctrl_nibble;
    logic       ctrl_is_data;
    logic       ctrl_active;
    logic       rom_drive;
    logic [3:0] rom_nibble;
    logic       ram_drive;
    logic [3:0] ram_nibble;

    saturn_phase_gen phase_gen_i (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_clk_en    (i_clk_en),
        .i_stall     (phase_stall),
        .o_phase     (o_phase),
        .o_strobe    (bus_strobe),
        .o_cycle_ctr (o_cycle_ctr)
    );

    // Hidden processor.
    saturn_bus_controller controller_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_strobe     (bus_strobe),
        .i_start      (i_start),
        .i_op         (i_op),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_rom_drive  (rom_drive),
        .i_rom_nibble (rom_nibble),
        .i_ram_drive  (ram_drive),
        .i_ram_nibble (ram_nibble),
        .i_char_valid (o_char_valid),
        .i_char_ready (i_char_ready),
        .o_nibble     (ctrl_nibble),
        .o_is_data    (ctrl_is_data),
        .o_active     (ctrl_active),
        .o_busy       (o_busy),
        .o_done       (o_done),
        .o_rdata      (o_rdata),
        .o_halt       (o_halt),
        .o_stall      (phase_stall)
    );

    saturn_hp48gx_rom rom_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_strobe  (bus_strobe),
        .i_active  (ctrl_active),
        .i_is_data (ctrl_is_data),
        .i_nibble  (ctrl_nibble),
        .o_drive   (rom_drive),
        .o_nibble  (rom_nibble)
    );

    saturn_sys_ram ram_i (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_strobe  (bus_strobe),
        .i_active  (ctrl_active),
        .i_is_data (ctrl_is_data),
        .i_nibble  (ctrl_nibble),
        .o_drive   (ram_drive),
        .o_nibble  (ram_nibble)
    );

    // Listens only. Never drives the bus.
    saturn_debug_port debug_port_i (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_strobe       (bus_strobe),
        .i_active       (ctrl_active),
        .i_is_data      (ctrl_is_data),
        .i_nibble       (ctrl_nibble),
        .i_char_ready   (i_char_ready),
        .o_char_to_send (o_char_to_send),
        .o_char_valid   (o_char_valid)
    );

endmodule

// File: logic/saturn_debug_port.sv
// Debug serial port. Pairs two nibble writes into a character and holds it.
`timescale 1ns/1ps
`include "saturn_bus_settings.svh"

module saturn_debug_port (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_strobe,
    input  logic       i_active,
    input  logic       i_is_data,
    input  logic [3:0] i_nibble,
    input  logic       i_char_ready,
    output logic [7:0] o_char_to_send,
    output logic       o_char_valid
);

    import saturn_bus_pkg::*;

    localparam int ADDR_NIBS = `SATURN_ADDR_W / 4;

    logic [`SATURN_ADDR_W-1:0] addr_q;
    logic [2:0]                nib_cnt;
    logic                      wr_pend;
    logic [3:0]                lo_q;       // Low half waiting for its mate.
    logic                      bus_cyc;
    logic                      shift_en;
    logic                      wr_cyc;     // Write data on the bus now.

    assign bus_cyc  = i_strobe && i_active;
    assign shift_en = bus_cyc && i_is_data && !wr_pend && (nib_cnt != ADDR_NIBS);
    assign wr_cyc   = bus_cyc && i_is_data && wr_pend;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            nib_cnt      <= 3'd0;
            wr_pend      <= 1'b0;
            o_char_valid <= 1'b0;
        end else begin
            if (o_char_valid && i_char_ready) o_char_valid <= 1'b0;   // Taken.
            if (bus_cyc) begin
                if (!i_is_data) begin
                    wr_pend <= (i_nibble == CMD_WRITE);
                    if (i_nibble == CMD_LOAD_ADDR) nib_cnt <= 3'd0;
                end else if (wr_pend) begin
                    wr_pend <= 1'b0;
                end else if (shift_en) begin
                    nib_cnt <= nib_cnt + 3'd1;
                end
            end
            // New character replaces a pending one.
            if (wr_cyc && addr_q == `SATURN_DBG_HI) o_char_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (shift_en) addr_q <= {i_nibble, addr_q[`SATURN_ADDR_W-1:4]};
        if (wr_cyc && addr_q == `SATURN_DBG_LO) lo_q <= i_nibble;
        if (wr_cyc && addr_q == `SATURN_DBG_HI) o_char_to_send <= {i_nibble, lo_q};
    end

endmodule

// File: logic/saturn_sys_ram.sv
// System RAM device. Nibble storage answering its own window of the bus.
`timescale 1ns/1ps
`include "saturn_bus_settings.svh"

module saturn_sys_ram (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_strobe,
    input  logic       i_active,
    input  logic       i_is_data,
    input  logic [3:0] i_nibble,
    output logic       o_drive,
    output logic [3:0] o_nibble
);

    import saturn_bus_pkg::*;

    localparam int ADDR_NIBS = `SATURN_ADDR_W / 4;
    localparam int RAM_AW    = $clog2(`SATURN_RAM_DEPTH);

    logic [3:0]                mem [`SATURN_RAM_DEPTH];
    logic [`SATURN_ADDR_W-1:0] addr_q;
    logic [`SATURN_ADDR_W-1:0] offset;     // Address within the window.
    logic [2:0]                nib_cnt;
    logic                      rd_pend;
    logic                      wr_pend;
    logic                      bus_cyc;
    logic                      shift_en;
    logic                      hit;

    assign bus_cyc  = i_strobe && i_active;
    assign shift_en = bus_cyc && i_is_data && !rd_pend && !wr_pend
                      && (nib_cnt != ADDR_NIBS);
    assign offset   = addr_q - `SATURN_RAM_BASE;
    assign hit      = (addr_q >= `SATURN_RAM_BASE) && (offset < `SATURN_RAM_DEPTH);
    assign o_drive  = rd_pend && i_active && i_is_data && hit;
    assign o_nibble = mem[offset[RAM_AW-1:0]];

    // Protocol tracking.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            nib_cnt <= 3'd0;
            rd_pend <= 1'b0;
            wr_pend <= 1'b0;
        end else if (bus_cyc) begin
            if (!i_is_data) begin
                rd_pend <= (i_nibble == CMD_READ);
                wr_pend <= (i_nibble == CMD_WRITE);
                if (i_nibble == CMD_LOAD_ADDR) nib_cnt <= 3'd0;
            end else if (rd_pend || wr_pend) begin
                rd_pend <= 1'b0;               // Data cycle over.
                wr_pend <= 1'b0;
            end else if (shift_en) begin
                nib_cnt <= nib_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (shift_en) addr_q <= {i_nibble, addr_q[`SATURN_ADDR_W-1:4]};
    end

    // Storage. Cleared on reset.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < `SATURN_RAM_DEPTH; i++) begin
                mem[i] <= 4'h0;
            end
        end else if (bus_cyc && i_is_data && wr_pend && hit) begin
            mem[offset[RAM_AW-1:0]] <= i_nibble;
        end
    end

endmodule

// File: logic/saturn_hp48gx_rom.sv
// Firmware ROM device. Tracks the bus address and answers reads from a fixed rule.
`timescale 1ns/1ps
`include "saturn_bus_settings.svh"

module saturn_hp48gx_rom (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_strobe,
    input  logic       i_active,
    input  logic       i_is_data,
    input  logic [3:0] i_nibble,
    output logic       o_drive,
    output logic [3:0] o_nibble
);

    import saturn_bus_pkg::*;

    localparam int ADDR_NIBS = `SATURN_ADDR_W / 4;

    logic [`SATURN_ADDR_W-1:0] addr_q;
    logic [2:0]                nib_cnt;    // Address nibbles since LOAD_ADDR.
    logic                      rd_pend;    // Next data cycle is a read.
    logic                      bus_cyc;
    logic                      shift_en;

    assign bus_cyc  = i_strobe && i_active;
    assign shift_en = bus_cyc && i_is_data && !rd_pend && (nib_cnt != ADDR_NIBS);
    assign o_drive  = rd_pend && i_active && i_is_data && (addr_q <= `SATURN_ROM_TOP);

    // Contents. Sum of the address nibbles, wraps at 16.
    always_comb begin
        o_nibble = 4'h0;
        for (int i = 0; i < ADDR_NIBS; i++) begin
            o_nibble = o_nibble + addr_q[4*i +: 4];
        end
    end

    // Protocol tracking. Writes fall through unanswered.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            nib_cnt <= 3'd0;
            rd_pend <= 1'b0;
        end else if (bus_cyc) begin
            if (!i_is_data) begin
                rd_pend <= (i_nibble == CMD_READ);
                if (i_nibble == CMD_LOAD_ADDR) nib_cnt <= 3'd0;
            end else if (rd_pend) begin
                rd_pend <= 1'b0;               // Read served.
            end else if (shift_en) begin
                nib_cnt <= nib_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (shift_en) addr_q <= {i_nibble, addr_q[`SATURN_ADDR_W-1:4]};
    end

endmodule

// File: logic/saturn_bus_controller.sv
// Bus master standing in for the CPU. Runs host requests as nibble transfers.
`timescale 1ns/1ps
`include "saturn_bus_settings.svh"

module saturn_bus_controller (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_strobe,
    input  logic                      i_start,
    input  saturn_bus_pkg::host_op_e  i_op,
    input  logic [`SATURN_ADDR_W-1:0] i_addr,
    input  logic [3:0]                i_wdata,
    input  logic                      i_rom_drive,
    input  logic [3:0]                i_rom_nibble,
    input  logic                      i_ram_drive,
    input  logic [3:0]                i_ram_nibble,
    input  logic                      i_char_valid,
    input  logic                      i_char_ready,
    output logic [3:0]                o_nibble,
    output logic                      o_is_data,
    output logic                      o_active,
    output logic                      o_busy,
    output logic                      o_done,
    output logic [3:0]                o_rdata,
    output logic                      o_halt,
    output logic                      o_stall
);

    import saturn_bus_pkg::*;

    localparam int ADDR_NIBS = `SATURN_ADDR_W / 4;

    ctrl_state_e               state;
    logic [2:0]                addr_ctr;    // Address nibble on the bus.
    host_op_e                  req_op;      // Latched request.
    logic [`SATURN_ADDR_W-1:0] req_addr;
    logic [3:0]                req_wdata;
    logic [3:0]                rd_q;        // Nibble caught in the data cycle.
    logic [3:0]                bus_in;      // Device mux result.
    logic                      accept;

    assign accept  = (state == S_IDLE) && i_start;
    assign o_busy  = (state != S_IDLE) && (state != S_HALTED);
    assign o_halt  = (state == S_HALTED);    // Sticky until reset.
    assign o_stall = i_char_valid && !i_char_ready;   // Serial output full.

    // ##########################################################################
    // Bus drive
    // ##########################################################################
    always_comb begin
        o_active  = 1'b1;
        o_is_data = 1'b1;
        o_nibble  = 4'h0;
        case (state)
            S_CMD_ADDR: begin
                o_is_data = 1'b0;
                o_nibble  = CMD_LOAD_ADDR;
            end
            S_ADDR:     o_nibble = req_addr[4*addr_ctr +: 4];   // Lowest first.
            S_CMD_XFER: begin
                o_is_data = 1'b0;
                o_nibble  = (req_op == OP_WRITE) ? CMD_WRITE : CMD_READ;
            end
            S_DATA:     o_nibble = (req_op == OP_WRITE) ? req_wdata : 4'h0;
            default: begin
                o_active  = 1'b0;    // Bus cycle unused.
                o_is_data = 1'b0;
            end
        endcase
    end

    // Last active device wins. RAM over ROM, zero when nobody drives.
    always_comb begin
        bus_in = 4'h0;
        if (i_rom_drive) bus_in = i_rom_nibble;
        if (i_ram_drive) bus_in = i_ram_nibble;
    end

    // ##########################################################################
    // Sequencer
    // ##########################################################################
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= S_IDLE;
            addr_ctr <= 3'd0;
            o_done   <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_start) state <= (i_op == OP_HALT) ? S_HALTED : S_CMD_ADDR;
                end
                S_CMD_ADDR: begin
                    if (i_strobe) begin
                        addr_ctr <= 3'd0;
                        state    <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (i_strobe) begin
                        addr_ctr <= addr_ctr + 3'd1;
                        if (addr_ctr == ADDR_NIBS - 1) state <= S_CMD_XFER;
                    end
                end
                S_CMD_XFER: if (i_strobe) state <= S_DATA;
                S_DATA:     if (i_strobe) state <= S_DONE;
                S_DONE: begin
                    if (i_strobe) begin
                        o_done <= 1'b1;    // Ninth strobe.
                        state  <= S_IDLE;
                    end
                end
                S_HALTED:   state <= S_HALTED;
                default:    state <= S_IDLE;
            endcase
        end
    end

    // Request and result payload.
    always_ff @(posedge i_clk) begin
        if (accept) begin
            req_op    <= i_op;
            req_addr  <= i_addr;
            req_wdata <= i_wdata;
        end
        if (i_strobe && state == S_DATA) rd_q <= bus_in;
        if (i_strobe && state == S_DONE && req_op != OP_WRITE) begin
            o_rdata <= rd_q;    // Same clock as o_done.
        end
    end

endmodule

// File: logic/saturn_phase_gen.sv
// Four-phase clock ring with one bus strobe per cycle and a bus cycle counter.
`timescale 1ns/1ps

module saturn_phase_gen (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_clk_en,
    input  logic        i_stall,
    output logic [1:0]  o_phase,
    output logic        o_strobe,
    output logic [31:0] o_cycle_ctr
);

    logic [3:0] ring;      // One-hot. Bit n is phase n.
    logic       advance;   // Ring moves on this clock.

    assign advance  = i_clk_en && !i_stall;
    assign o_strobe = advance && ring[3];   // Phase 3 closes the bus cycle.

    // Phase number from the ring.
    always_comb begin
        o_phase = 2'd0;
        if (ring[1]) o_phase = 2'd1;
        if (ring[2]) o_phase = 2'd2;
        if (ring[3]) o_phase = 2'd3;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ring        <= 4'b0001;
            o_cycle_ctr <= 32'd0;
        end else begin
            if (advance) begin
                ring <= {ring[2:0], ring[3]};   // Rotate.
            end
            if (o_strobe) begin
                o_cycle_ctr <= o_cycle_ctr + 32'd1;   // One per bus cycle.
            end
        end
    end

endmodule

// File: logic/saturn_bus_pkg.sv
// Shared types for host opcodes, bus command nibbles and controller states.
package saturn_bus_pkg;

    // Host request opcodes.
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_HALT  = 2'd2
    } host_op_e;

    // Command nibbles as seen on the bus.
    typedef enum logic [3:0] {
        CMD_LOAD_ADDR = 4'h4,
        CMD_READ      = 4'h5,
        CMD_WRITE     = 4'h6
    } bus_cmd_e;

    // Controller sequence. One transfer per strobe.
    typedef enum logic [2:0] {
        S_IDLE     = 3'd0,
        S_CMD_ADDR = 3'd1,   // LOAD_ADDR on the bus.
        S_ADDR     = 3'd2,   // Five address nibbles.
        S_CMD_XFER = 3'd3,   // READ or WRITE.
        S_DATA     = 3'd4,
        S_DONE     = 3'd5,   // Idle bus cycle, then report.
        S_HALTED   = 3'd6
    } ctrl_state_e;

endpackage

// File: logic/saturn_bus_settings.svh
// Memory map and sizing constants for the nibble-serial system bus.
`ifndef SATURN_BUS_SETTINGS_SVH
`define SATURN_BUS_SETTINGS_SVH

// ##########################################################################
// Address space
// ##########################################################################
`define SATURN_ADDR_W    20          // Five nibbles per address.
`define SATURN_ROM_TOP   20'h7FFFF   // Last firmware nibble.

// System RAM window.
`define SATURN_RAM_BASE  20'h80000
`define SATURN_RAM_DEPTH 64          // In nibbles.

// Debug serial port pair.
`define SATURN_DBG_LO    20'hFFFF0   // Low nibble of a character.
`define SATURN_DBG_HI    20'hFFFF1   // High nibble, sends it.

`endif
